/* verilog/mem_req_pkg.sv */
// Requestor-side types for two requestors only; addresses are 32-bit byte addresses with no alignment check
`default_nettype none

package mem_req_pkg;

  // --------------------
  // Address types
  // --------------------

  // Byte address
  // Used for the requestor base and for the formed cache address
  typedef logic [31:0] mem_addr_t;

  // Offset added to the base
  // Unsigned, the sum wraps at 32 bits
  typedef logic [31:0] mem_offset_t;

  // --------------------
  // Requestor number
  // --------------------

  // One bit is enough for the two requestors
  // Also carried through to the cache port as the response tag
  typedef logic [0:0] src_id_t;

endpackage : mem_req_pkg

`default_nettype wire

/* verilog/cache_req_pkg.sv */
// Cache-side types for a read-only request path; no write data, strobes or invalidate fields exist
`default_nettype none

package cache_req_pkg;

  // --------------------
  // Cache request payload
  // --------------------

  // Formed request, 33 bits
  // Address in the upper bits, source tag in bit 0
  typedef struct packed {
    mem_req_pkg::mem_addr_t addr;
    mem_req_pkg::src_id_t   src;
  } cache_req_t;

  // --------------------
  // Issue FSM states
  // --------------------

  // RESET and IDLE are one-cycle start-up steps
  // READ pops the FIFO head when credit allows
  // WAIT parks while the issued request sits untaken
  typedef enum logic [1:0] {
    ISSUE_RESET = 2'd0,
    ISSUE_IDLE  = 2'd1,
    ISSUE_READ  = 2'd2,
    ISSUE_WAIT  = 2'd3
  } issue_state_t;

  // Credit counter width is not fixed here
  // It follows OUTSTANDING_MAX inside the issue stage

endpackage : cache_req_pkg

`default_nettype wire

/* verilog/cache_req_if.sv */
// One formed cache request per transfer; source must hold valid and req stable until valid and ready meet
`timescale 1ns/1ps
`default_nettype none

interface cache_req_if;

  // --------------------
  // Handshake
  // --------------------

  // Request present
  logic valid;

  // Sink can take it this cycle
  logic ready;

  // --------------------
  // Payload
  // --------------------

  // Formed address plus source tag
  cache_req_pkg::cache_req_t req;

  // Producer side
  // Drives valid and payload, watches ready
  modport source (
    output valid,
    output req,
    input  ready
  );

  // Consumer side
  modport sink (
    input  valid,
    input  req,
    output ready
  );

endinterface : cache_req_if

`default_nettype wire

/* verilog/request_arbiter.sv */
// Two requestors only; each input register holds one request until its formed transfer, so a source gets at most one in flight here
`timescale 1ns/1ps
`default_nettype none

module request_arbiter (
  input  wire logic                     ap_clk,
  input  wire logic                     control_areset,
  input  wire logic                     req_valid_0,
  input  wire logic                     req_valid_1,
  output logic                          req_ready_0,
  output logic                          req_ready_1,
  input  wire mem_req_pkg::mem_addr_t   req_base_0,
  input  wire mem_req_pkg::mem_addr_t   req_base_1,
  input  wire mem_req_pkg::mem_offset_t req_offset_0,
  input  wire mem_req_pkg::mem_offset_t req_offset_1,
  cache_req_if.source                   formed
);

  // --------------------
  // Declarations
  // --------------------

  // Per-requestor input registers
  logic [1:0]               in_valid;
  mem_req_pkg::mem_addr_t   in_base   [2];
  mem_req_pkg::mem_offset_t in_offset [2];
  logic [1:0]               in_take;

  // Low through reset, high from the first cycle after
  logic accept_en;

  // Round-robin pointer, requestor 0 first after reset
  mem_req_pkg::src_id_t rr_ptr;

  // Full and not already on the output
  logic [1:0]           pending;
  logic                 formed_fire;
  logic                 load;
  logic                 grant_hit;
  mem_req_pkg::src_id_t grant;

  // --------------------
  // Requestor side
  // --------------------

  assign req_ready_0 = accept_en & ~in_valid[0];
  assign req_ready_1 = accept_en & ~in_valid[1];
  assign in_take[0]  = req_valid_0 & req_ready_0;
  assign in_take[1]  = req_valid_1 & req_ready_1;

  assign formed_fire = formed.valid & formed.ready;

  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      accept_en <= 1'b0;
      in_valid  <= 2'b00;
    end else begin
      accept_en <= 1'b1;
      for (int n = 0; n < 2; n++) begin
        // Refill cannot coincide with the release, ready is low while full
        if (in_take[n]) begin
          in_valid[n] <= 1'b1;
        end else if (formed_fire && (formed.req.src == mem_req_pkg::src_id_t'(n))) begin
          in_valid[n] <= 1'b0;
        end
      end
    end
  end

  // Payload capture, no reset
  always_ff @(posedge ap_clk) begin
    if (in_take[0]) begin
      in_base[0]   <= req_base_0;
      in_offset[0] <= req_offset_0;
    end
    if (in_take[1]) begin
      in_base[1]   <= req_base_1;
      in_offset[1] <= req_offset_1;
    end
  end

  // --------------------
  // Round-robin grant
  // --------------------

  // The owner of the output is masked out so the other side wins next
  assign pending[0] = in_valid[0] & ~(formed.valid & (formed.req.src == 1'b0));
  assign pending[1] = in_valid[1] & ~(formed.valid & (formed.req.src == 1'b1));
  assign grant_hit  = |pending;
  assign grant      = pending[rr_ptr] ? rr_ptr : ~rr_ptr;

  // Output register free or emptying this edge
  assign load = ~formed.valid | formed.ready;

  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      formed.valid <= 1'b0;
      rr_ptr       <= 1'b0;
    end else if (load) begin
      formed.valid <= grant_hit;
      if (grant_hit) begin
        rr_ptr <= ~grant;
      end
    end
  end

  // Address forming, base plus offset tagged with source
  always_ff @(posedge ap_clk) begin
    if (load && grant_hit) begin
      formed.req.addr <= in_base[grant] + in_offset[grant];
      formed.req.src  <= grant;
    end
  end

  // Hold rule toward the FIFO
  formed_hold_a : assert property (@(posedge ap_clk) disable iff (control_areset)
    formed.valid && !formed.ready |=> formed.valid && $stable(formed.req));

endmodule : request_arbiter

`default_nettype wire

/* verilog/request_issue.sv */
// FIFO_DEPTH must be a power of two of at least 2; credits are spent at the issued transfer, not at the cache port
`timescale 1ns/1ps
`default_nettype none

module request_issue #(
  parameter int FIFO_DEPTH      = 16,
  parameter int OUTSTANDING_MAX = 4
) (
  input  wire logic  ap_clk,
  input  wire logic  control_areset,
  cache_req_if.sink  formed,
  cache_req_if.source issued,
  input  wire logic  cache_resp_done
);

  // --------------------
  // Declarations
  // --------------------

  localparam int PTR_W    = $clog2(FIFO_DEPTH);
  localparam int CREDIT_W = $clog2(OUTSTANDING_MAX + 1);

  // Circular request store
  cache_req_pkg::cache_req_t fifo_mem [FIFO_DEPTH];

  // Extra wrap bit on each pointer
  logic [PTR_W:0] wr_ptr;
  logic [PTR_W:0] rd_ptr;
  logic [PTR_W:0] fill;
  logic           fifo_full;
  logic           fifo_empty;
  logic           fifo_wr;
  logic           fifo_rd;

  // Outstanding-transaction credits
  logic [CREDIT_W-1:0] credit;
  logic                credit_ok;
  logic                issue_fire;

  cache_req_pkg::issue_state_t state;
  cache_req_pkg::issue_state_t state_next;

  // --------------------
  // FIFO
  // --------------------

  // Occupancy never passes FIFO_DEPTH, so top bit set means full
  assign fill       = wr_ptr - rd_ptr;
  assign fifo_full  = fill[PTR_W];
  assign fifo_empty = (fill == '0);

  assign formed.ready = ~fifo_full;
  assign fifo_wr      = formed.valid & ~fifo_full;

  // Entry on issued is firing this edge, so it still needs its own credit
  assign credit_ok  = credit > CREDIT_W'(issued.valid);
  assign issue_fire = issued.valid & issued.ready;

  // Pop only in READ, with the issue slot free or emptying
  assign fifo_rd = (state == cache_req_pkg::ISSUE_READ) & ~fifo_empty & credit_ok &
                   (~issued.valid | issued.ready);

  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (fifo_wr) begin
        wr_ptr <= wr_ptr + (PTR_W + 1)'(1);
      end
      if (fifo_rd) begin
        rd_ptr <= rd_ptr + (PTR_W + 1)'(1);
      end
    end
  end

  // Storage, no reset
  always_ff @(posedge ap_clk) begin
    if (fifo_wr) begin
      fifo_mem[wr_ptr[PTR_W-1:0]] <= formed.req;
    end
  end

  // --------------------
  // Credit counter
  // --------------------

  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      credit <= CREDIT_W'(OUTSTANDING_MAX);
    end else begin
      // Spend and return in one cycle cancel out
      case ({issue_fire, cache_resp_done})
        2'b10:   credit <= credit - CREDIT_W'(1);
        2'b01:   credit <= credit + CREDIT_W'(1);
        default: credit <= credit;
      endcase
    end
  end

  // --------------------
  // Issue FSM
  // --------------------

  always_comb begin
    state_next = state;
    case (state)
      cache_req_pkg::ISSUE_RESET: state_next = cache_req_pkg::ISSUE_IDLE;
      cache_req_pkg::ISSUE_IDLE:  state_next = cache_req_pkg::ISSUE_READ;
      cache_req_pkg::ISSUE_READ: begin
        // Result stage back-pressured
        if (issued.valid && !issued.ready) begin
          state_next = cache_req_pkg::ISSUE_WAIT;
        end
      end
      cache_req_pkg::ISSUE_WAIT: begin
        if (issued.ready) begin
          state_next = cache_req_pkg::ISSUE_READ;
        end
      end
      default: state_next = cache_req_pkg::ISSUE_RESET;
    endcase
  end

  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      state        <= cache_req_pkg::ISSUE_RESET;
      issued.valid <= 1'b0;
    end else begin
      state <= state_next;
      if (fifo_rd) begin
        issued.valid <= 1'b1;
      end else if (issue_fire) begin
        issued.valid <= 1'b0;
      end
    end
  end

  // Head lands on issued one edge after the read
  always_ff @(posedge ap_clk) begin
    if (fifo_rd) begin
      issued.req <= fifo_mem[rd_ptr[PTR_W-1:0]];
    end
  end

  // --------------------
  // Checks
  // --------------------

  // Cache returns no more than it was given
  credit_max_a : assert property (@(posedge ap_clk) disable iff (control_areset)
    credit <= CREDIT_W'(OUTSTANDING_MAX));

  // An issued request always carries a credit
  credit_underflow_a : assert property (@(posedge ap_clk) disable iff (control_areset)
    (credit == '0) |-> !issue_fire);

  // Writing into a full FIFO would push occupancy past the depth
  fifo_overflow_a : assert property (@(posedge ap_clk) disable iff (control_areset)
    fill <= (PTR_W + 1)'(FIFO_DEPTH));

endmodule : request_issue

`default_nettype wire

/* verilog/cache_port_stage.sv */
// Two-entry skid stage; cache port values never change while cache_req_valid is high and cache_req_ready is low
`timescale 1ns/1ps
`default_nettype none

module cache_port_stage (
  input  wire logic              ap_clk,
  input  wire logic              control_areset,
  cache_req_if.sink              issued,
  output logic                   cache_req_valid,
  output mem_req_pkg::mem_addr_t cache_req_addr,
  output mem_req_pkg::src_id_t   cache_req_src,
  input  wire logic              cache_req_ready
);

  // --------------------
  // Declarations
  // --------------------

  // Output entry, drives the cache port
  logic                      out_valid;
  cache_req_pkg::cache_req_t out_req;

  // Skid entry for the request already in flight
  logic                      skid_valid;
  cache_req_pkg::cache_req_t skid_req;

  logic in_fire;
  logic out_free;

  // --------------------
  // Datapath
  // --------------------

  // Ready straight from a register
  assign issued.ready = ~skid_valid;
  assign in_fire      = issued.valid & ~skid_valid;

  // Output empty or being taken this edge
  assign out_free = ~out_valid | cache_req_ready;

  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else begin
      if (out_free) begin
        // Skid drains first to keep order
        out_valid  <= skid_valid | in_fire;
        skid_valid <= 1'b0;
      end else if (in_fire) begin
        skid_valid <= 1'b1;
      end
    end
  end

  // Payload, no reset
  always_ff @(posedge ap_clk) begin
    if (out_free) begin
      if (skid_valid) begin
        out_req <= skid_req;
      end else if (in_fire) begin
        out_req <= issued.req;
      end
    end else if (in_fire) begin
      skid_req <= issued.req;
    end
  end

  assign cache_req_valid = out_valid;
  assign cache_req_addr  = out_req.addr;
  assign cache_req_src   = out_req.src;

  // Cache sees a stable request until it takes it
  port_hold_a : assert property (@(posedge ap_clk) disable iff (control_areset)
    cache_req_valid && !cache_req_ready |=>
      cache_req_valid && $stable(cache_req_addr) && $stable(cache_req_src));

endmodule : cache_port_stage

`default_nettype wire

/* verilog/cache_request_generator.sv */
// Read requests only; minimum latency is 4 cycles from requestor transfer to cache_req_valid, one credit per cache_resp_done pulse
`timescale 1ns/1ps
`default_nettype none

module cache_request_generator #(
  parameter int FIFO_DEPTH      = 16,
  parameter int OUTSTANDING_MAX = 4
) (
  input  wire logic                     ap_clk,
  input  wire logic                     control_areset,
  // Requestor 0
  input  wire logic                     req_valid_0,
  output logic                          req_ready_0,
  input  wire mem_req_pkg::mem_addr_t   req_base_0,
  input  wire mem_req_pkg::mem_offset_t req_offset_0,
  // Requestor 1
  input  wire logic                     req_valid_1,
  output logic                          req_ready_1,
  input  wire mem_req_pkg::mem_addr_t   req_base_1,
  input  wire mem_req_pkg::mem_offset_t req_offset_1,
  // Cache request port
  output logic                          cache_req_valid,
  output mem_req_pkg::mem_addr_t        cache_req_addr,
  output mem_req_pkg::src_id_t          cache_req_src,
  input  wire logic                     cache_req_ready,
  // Credit return
  input  wire logic                     cache_resp_done
);

  // --------------------
  // Stage links
  // --------------------

  // Decode to execute
  cache_req_if formed_if ();

  // Execute to result
  cache_req_if issued_if ();

  // Decode stage
  request_arbiter u_request_arbiter (
    .ap_clk         (ap_clk),
    .control_areset (control_areset),
    .req_valid_0    (req_valid_0),
    .req_valid_1    (req_valid_1),
    .req_ready_0    (req_ready_0),
    .req_ready_1    (req_ready_1),
    .req_base_0     (req_base_0),
    .req_base_1     (req_base_1),
    .req_offset_0   (req_offset_0),
    .req_offset_1   (req_offset_1),
    .formed         (formed_if.source)
  );

  // Execute stage, FIFO plus credits
  request_issue #(
    .FIFO_DEPTH      (FIFO_DEPTH),
    .OUTSTANDING_MAX (OUTSTANDING_MAX)
  ) u_request_issue (
    .ap_clk          (ap_clk),
    .control_areset  (control_areset),
    .formed          (formed_if.sink),
    .issued          (issued_if.source),
    .cache_resp_done (cache_resp_done)
  );

  // Result stage
  cache_port_stage u_cache_port_stage (
    .ap_clk          (ap_clk),
    .control_areset  (control_areset),
    .issued          (issued_if.sink),
    .cache_req_valid (cache_req_valid),
    .cache_req_addr  (cache_req_addr),
    .cache_req_src   (cache_req_src),
    .cache_req_ready (cache_req_ready)
  );

endmodule : cache_request_generator

`default_nettype wire

/* sim/cache_request_generator_tb.sv */
// Run from the project root so sim/request_input.txt is found; needs 14 requests per requestor and FIFO_DEPTH 8 so the stall phase fills every stage
`timescale 1ns/1ps
`default_nettype none

module cache_request_generator_tb;

  localparam int FIFO_DEPTH      = 8;
  localparam int OUTSTANDING_MAX = 4;
  localparam int FAIR_N          = 3;
  localparam int STALL_N         = 8;
  localparam int MIXED_N         = 3;
  localparam int PER_SRC         = FAIR_N + STALL_N + MIXED_N;

  // --------------------
  // DUT signals
  // --------------------

  logic        ap_clk;
  logic        control_areset  = 1'b1;
  logic        req_valid_0     = 1'b0;
  logic        req_valid_1     = 1'b0;
  logic        req_ready_0;
  logic        req_ready_1;
  logic [31:0] req_base_0      = '0;
  logic [31:0] req_base_1      = '0;
  logic [31:0] req_offset_0    = '0;
  logic [31:0] req_offset_1    = '0;
  logic        cache_req_valid;
  logic [31:0] cache_req_addr;
  logic [0:0]  cache_req_src;
  logic        cache_req_ready = 1'b0;
  logic        cache_resp_done = 1'b0;

  // Per-requestor stimulus and expected addresses
  logic [31:0] base0_q [$];
  logic [31:0] off0_q  [$];
  logic [31:0] exp0_q  [$];
  logic [31:0] base1_q [$];
  logic [31:0] off1_q  [$];
  logic [31:0] exp1_q  [$];

  // Cache model state
  int          due_q [$];
  logic [31:0] rng_cache = 32'd83;
  logic [31:0] rng_drv [2];
  bit          monitor_on   = 1'b0;
  bit          hold_resp    = 1'b0;
  bit          random_ready = 1'b0;
  bit          fair_phase   = 1'b0;
  bit          stalled_prev = 1'b0;
  logic [31:0] held_addr;
  logic [0:0]  held_src;
  logic [0:0]  last_src;
  int          transfers       = 0;
  int          pulses          = 0;
  int          fair_seen       = 0;
  int          stall_transfers = 0;
  int          low_run         = 0;
  int          num_req         = 0;
  int          cycle_count     = 0;
  int          cycle_limit     = 0;

  cache_request_generator #(
    .FIFO_DEPTH      (FIFO_DEPTH),
    .OUTSTANDING_MAX (OUTSTANDING_MAX)
  ) dut0 (
    .ap_clk          (ap_clk),
    .control_areset  (control_areset),
    .req_valid_0     (req_valid_0),
    .req_ready_0     (req_ready_0),
    .req_base_0      (req_base_0),
    .req_offset_0    (req_offset_0),
    .req_valid_1     (req_valid_1),
    .req_ready_1     (req_ready_1),
    .req_base_1      (req_base_1),
    .req_offset_1    (req_offset_1),
    .cache_req_valid (cache_req_valid),
    .cache_req_addr  (cache_req_addr),
    .cache_req_src   (cache_req_src),
    .cache_req_ready (cache_req_ready),
    .cache_resp_done (cache_resp_done)
  );

  // 40 ns period
  initial begin
    ap_clk = 1'b0;
    forever #20 ap_clk = ~ap_clk;
  end

  // --------------------
  // Failure reporting
  // --------------------

  task automatic abort_failed();
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic value_mismatch(input string sig, input logic [31:0] expected,
                                input logic [31:0] actual);
    $display("[FAIL] time %0t: %s expected %h, got %h", $time, sig, expected, actual);
    abort_failed();
  endtask

  task automatic run_problem(input string what);
    $display("ERROR at time %0t: %s", $time, what);
    abort_failed();
  endtask

  // 32-bit xorshift step
  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // --------------------
  // Stimulus file
  // --------------------

  task automatic load_requests();
    int          fd;
    int          n;
    string       line;
    logic [31:0] s;
    logic [31:0] b;
    logic [31:0] o;
    logic [31:0] e;
    fd = $fopen("sim/request_input.txt", "r");
    assert (fd != 0) else run_problem("cannot open sim/request_input.txt");
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      // Skip comments and blank lines
      if ((n > 0) && (line.substr(0, 0) != "#")) begin
        n = $sscanf(line, "%h %h %h %h", s, b, o, e);
        if (n == 4) begin
          assert (s <= 32'd1) else run_problem("source number in data file is not 0 or 1");
          if (s == 32'd0) begin
            base0_q.push_back(b);
            off0_q.push_back(o);
            exp0_q.push_back(e);
          end else begin
            base1_q.push_back(b);
            off1_q.push_back(o);
            exp1_q.push_back(e);
          end
          num_req++;
        end else if (n > 0) begin
          run_problem("data file line does not hold four hex fields");
        end
      end
    end
    $fclose(fd);
  endtask

  // --------------------
  // Requestor drivers
  // --------------------

  function automatic logic ready_of(input int src);
    return (src == 0) ? req_ready_0 : req_ready_1;
  endfunction

  task automatic drive_idle(input int src);
    if (src == 0) begin
      req_valid_0 = 1'b0;
    end else begin
      req_valid_1 = 1'b0;
    end
  endtask

  task automatic drive_request(input int src);
    if (src == 0) begin
      req_valid_0  = 1'b1;
      req_base_0   = base0_q.pop_front();
      req_offset_0 = off0_q.pop_front();
    end else begin
      req_valid_1  = 1'b1;
      req_base_1   = base1_q.pop_front();
      req_offset_1 = off1_q.pop_front();
    end
  endtask

  // Valid held until taken
  // Optional random idle gaps before each request
  task automatic offer_requests(input int src, input int count, input bit gaps);
    int gap;
    for (int i = 0; i < count; i++) begin
      gap = 0;
      if (gaps) begin
        rng_drv[src] = xorshift32(rng_drv[src]);
        gap = int'(rng_drv[src][1:0]);
      end
      repeat (gap) begin
        @(negedge ap_clk);
        drive_idle(src);
      end
      @(negedge ap_clk);
      drive_request(src);
      while (!ready_of(src)) @(negedge ap_clk);
      // Transfer lands on this edge
      @(posedge ap_clk);
    end
    @(negedge ap_clk);
    drive_idle(src);
  endtask

  // --------------------
  // Cache model and checks
  // --------------------

  task automatic score_transfer();
    logic [31:0] expected;
    if (cache_req_src == 1'b0) begin
      assert (exp0_q.size() > 0) else run_problem("extra cache request from requestor 0");
      expected = exp0_q.pop_front();
    end else begin
      assert (exp1_q.size() > 0) else run_problem("extra cache request from requestor 1");
      expected = exp1_q.pop_front();
    end
    assert (cache_req_addr == expected)
      else value_mismatch("cache_req_addr", expected, cache_req_addr);
    transfers++;
    if (fair_phase) begin
      if (fair_seen > 0) begin
        assert (cache_req_src != last_src)
          else value_mismatch("cache_req_src", {31'd0, ~last_src}, 32'(cache_req_src));
      end
      last_src = cache_req_src;
      fair_seen++;
    end
    if (hold_resp) begin
      stall_transfers++;
      assert (stall_transfers <= OUTSTANDING_MAX)
        else run_problem("cache request accepted with every credit already spent");
    end
    // Response 1 to 6 cycles later
    rng_cache = xorshift32(rng_cache);
    due_q.push_back(cycle_count + 1 + int'(rng_cache % 32'd6));
  endtask

  // Inputs change and outputs are sampled on the falling edge
  always @(negedge ap_clk) begin
    if (monitor_on) begin
      if (stalled_prev) begin
        assert (cache_req_valid)
          else run_problem("cache_req_valid dropped before the cache took it");
        assert (cache_req_addr == held_addr)
          else value_mismatch("cache_req_addr", held_addr, cache_req_addr);
        assert (cache_req_src == held_src)
          else value_mismatch("cache_req_src", 32'(held_src), 32'(cache_req_src));
      end
      cache_resp_done = 1'b0;
      if (!hold_resp && (due_q.size() > 0)) begin
        if (due_q[0] <= cycle_count) begin
          void'(due_q.pop_front());
          cache_resp_done = 1'b1;
          pulses++;
        end
      end
      if (random_ready) begin
        rng_cache = xorshift32(rng_cache);
        cache_req_ready = (rng_cache[1:0] != 2'b00);
      end else begin
        cache_req_ready = 1'b1;
      end
      if (cache_req_valid && cache_req_ready) begin
        score_transfer();
      end
      assert (transfers - pulses <= OUTSTANDING_MAX)
        else run_problem("more cache requests outstanding than there are credits");
      // Run length of both requestors blocked
      if (!req_ready_0 && !req_ready_1) begin
        low_run++;
      end else begin
        low_run = 0;
      end
      stalled_prev = cache_req_valid && !cache_req_ready;
      held_addr    = cache_req_addr;
      held_src     = cache_req_src;
    end
  end

  // Watchdog
  always @(posedge ap_clk) begin
    cycle_count = cycle_count + 1;
    if ((cycle_limit > 0) && (cycle_count > cycle_limit)) begin
      run_problem($sformatf("timeout, the run did not finish within %0d cycles", cycle_limit));
    end
  end

  task automatic check_idle_outputs();
    assert (cache_req_valid == 1'b0)
      else value_mismatch("cache_req_valid", 32'd0, 32'(cache_req_valid));
    assert (req_ready_0 == 1'b0) else value_mismatch("req_ready_0", 32'd0, 32'(req_ready_0));
    assert (req_ready_1 == 1'b0) else value_mismatch("req_ready_1", 32'd0, 32'(req_ready_1));
  endtask

  // All seen and every credit back
  task automatic wait_drained(input int target);
    do @(posedge ap_clk); while (!((transfers == target) && (transfers == pulses)));
  endtask

  // --------------------
  // Test sequence
  // --------------------

  initial begin
    rng_drv[0] = xorshift32(32'd83);
    rng_drv[1] = xorshift32(rng_drv[0]);
    load_requests();
    assert ((exp0_q.size() == PER_SRC) && (exp1_q.size() == PER_SRC))
      else run_problem("data file must hold 14 requests per requestor");
    cycle_limit = 40 * num_req + 200;

    // Reset held 10 cycles and released on a falling edge
    repeat (10) begin
      @(negedge ap_clk);
      check_idle_outputs();
    end
    control_areset = 1'b0;
    @(negedge ap_clk);
    assert (cache_req_valid == 1'b0)
      else value_mismatch("cache_req_valid", 32'd0, 32'(cache_req_valid));
    assert (req_ready_0 == 1'b1) else value_mismatch("req_ready_0", 32'd1, 32'(req_ready_0));
    assert (req_ready_1 == 1'b1) else value_mismatch("req_ready_1", 32'd1, 32'(req_ready_1));

    // Fairness phase with both always valid and the cache always ready
    @(posedge ap_clk);
    monitor_on = 1'b1;
    fair_phase = 1'b1;
    fork
      offer_requests(0, FAIR_N, 1'b0);
      offer_requests(1, FAIR_N, 1'b0);
    join
    wait_drained(2 * FAIR_N);
    fair_phase = 1'b0;

    // Credit stall with responses withheld until the whole path backs up
    hold_resp       = 1'b1;
    random_ready    = 1'b1;
    stall_transfers = 0;
    fork
      offer_requests(0, STALL_N, 1'b0);
      offer_requests(1, STALL_N, 1'b0);
      begin
        do @(posedge ap_clk);
        while (!((low_run >= 16) && (stall_transfers == OUTSTANDING_MAX)));
        // No further transfer may come while responses are withheld
        repeat (16) @(posedge ap_clk);
        hold_resp = 1'b0;
      end
    join
    wait_drained(2 * (FAIR_N + STALL_N));

    // Mixed traffic with gaps and random back-pressure
    fork
      offer_requests(0, MIXED_N, 1'b1);
      offer_requests(1, MIXED_N, 1'b1);
    join
    wait_drained(num_req);

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule : cache_request_generator_tb

`default_nettype wire

/* cache_req_gen.f */
verilog/mem_req_pkg.sv
verilog/cache_req_pkg.sv
verilog/cache_req_if.sv
verilog/request_arbiter.sv
verilog/request_issue.sv
verilog/cache_port_stage.sv
verilog/cache_request_generator.sv
sim/cache_request_generator_tb.sv

/* Makefile */
# Verilator build and run for the cache request generator

VERILATOR  ?= verilator
TOP        := cache_request_generator_tb
RTL_TOP    := cache_request_generator
FILELIST   := cache_req_gen.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/1ps

SOURCES    := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# Pass only if the run log holds the pass line
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/request_input.txt */
# src base offset expected_addr, all hex, expected_addr is base plus offset modulo 2^32
# per requestor in order: 3 fairness, 8 credit stall, 3 mixed traffic
0 00001000 00000010 00001010
1 20000000 00000040 20000040
0 00002000 00000004 00002004
1 20000100 00000080 20000180
0 10000000 00000ff0 10000ff0
1 30000000 00001000 30001000
0 0000a000 00000a00 0000aa00
1 0badc000 00000010 0badc010
0 00400000 00012340 00412340
1 40000000 00000200 40000200
0 fffffff0 00000020 00000010
1 0000ff00 00000100 00010000
0 12345678 00000008 12345680
1 55555555 11111111 66666666
0 80000000 7fffffff ffffffff
1 00abcdef 00000011 00abce00
0 0000fffc 00000004 00010000
1 7ffffff8 00000008 80000000
0 00c00000 00000100 00c00100
1 00100000 000fffff 001fffff
0 00003000 00000030 00003030
1 01000000 00000c00 01000c00
0 00005000 00000500 00005500
1 00020000 00002000 00022000
0 000f0000 00010000 00100000
1 6000fff0 00000010 60010000
0 deadbee0 0000000f deadbeef
1 cafe0000 0000babe cafebabe
